// File: Makefile
VERILATOR ?= verilator
TOP ?= replayQueueTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
hdl/replayPkg.sv
hdl/replayLaneCheck.sv
hdl/replayQueueStore.sv
hdl/replayIssueReg.sv
hdl/replayQueue.sv
verification/replayQueue_assert.sv
verification/replayQueueTb.sv

// File: hdl/replayIssueReg.sv
/*
 * Replay issue register
 * Decides the pop of the head entry, registers the surviving lanes
 * and the replay strobe, and raises the upper-stage stall
 */

module replayIssueReg #(
    parameter int LANE_NUM = 2,
    parameter int ENTRY_NUM = 16,
    parameter int STALL_MARGIN = 3,
    parameter int ACTIVE_LIST_NUM = 32
) (
    input  logic clk,
    input  logic rstN,
    input  logic headReady,
    input  logic [LANE_NUM-1:0] headValid,
    input  replayPkg::replayOpType [LANE_NUM-1:0] headOp,
    input  logic [LANE_NUM-1:0][$clog2(ACTIVE_LIST_NUM)-1:0] headAlPtr,
    input  logic [LANE_NUM-1:0][7:0] headTag,
    input  logic [LANE_NUM-1:0] laneFlushed,
    input  logic [LANE_NUM-1:0] laneBlocked,
    input  logic [$clog2(ENTRY_NUM+1)-1:0] count,
    output logic pop,
    output logic replay,
    output logic [LANE_NUM-1:0] repValid,
    output replayPkg::replayOpType [LANE_NUM-1:0] repOp,
    output logic [LANE_NUM-1:0][$clog2(ACTIVE_LIST_NUM)-1:0] repAlPtr,
    output logic [LANE_NUM-1:0][7:0] repTag,
    output logic stallUpper
);

    localparam int cntWidth = $clog2(ENTRY_NUM + 1);
    localparam int stallLevel = (ENTRY_NUM > STALL_MARGIN) ? ENTRY_NUM - STALL_MARGIN : 0;

    logic almostFull;

    // One waiting load holds the whole entry
    assign pop = headReady && !(|laneBlocked);

    // Control part of the output stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            replay <= 1'b0;
            repValid <= '0;
        end else begin
            replay <= pop;
            if (pop) begin
                repValid <= headValid & ~laneFlushed;
            end else begin
                repValid <= '0;
            end
        end
    end

    // Payload, only meaningful under repValid
    always_ff @(posedge clk) begin
        if (pop) begin
            repOp <= headOp;
            repAlPtr <= headAlPtr;
            repTag <= headTag;
        end
    end

    // Leaves room for ops still in flight once the stall takes effect
    assign almostFull = (count >= cntWidth'(stallLevel));

    assign stallUpper = replay || almostFull;

endmodule

// File: hdl/replayLaneCheck.sv
/*
 * Head lane check
 * Flags a lane caught by a selective flush and a load still
 * waiting for its MSHR data
 */

module replayLaneCheck #(
    parameter int MSHR_NUM = 4,
    parameter int ACTIVE_LIST_NUM = 32
) (
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] alPtr,
    input  replayPkg::replayOpType op,
    input  logic hasMshr,
    input  logic [$clog2(MSHR_NUM)-1:0] mshrId,
    input  logic valid,
    input  logic recValidRange,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] recHead,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] recTail,
    input  logic recAll,
    input  logic flushStart,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] flushHead,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] flushTail,
    input  logic flushAll,
    input  logic [MSHR_NUM-1:0] mshrValid,
    input  logic [MSHR_NUM-1:0] mshrDataReady,
    output logic flushed,
    output logic blocked
);
    import replayPkg::*;

    localparam int alWidth = $clog2(ACTIVE_LIST_NUM);

    logic waitData;

    // Walks forward from head, tail itself excluded
    function automatic logic inRange(
        input logic [alWidth-1:0] ptr,
        input logic [alWidth-1:0] head,
        input logic [alWidth-1:0] tail,
        input logic all
    );
        logic hit;
        if (all) begin
            hit = 1'b1;
        end else if (head <= tail) begin
            hit = (ptr >= head) && (ptr < tail);
        end else begin
            hit = (ptr >= head) || (ptr < tail);
        end
        return hit;
    endfunction

    // Recorded range lags recovery by a cycle, so the arriving one is checked too
    assign flushed = (recValidRange && inRange(alPtr, recHead, recTail, recAll))
                  || (flushStart && inRange(alPtr, flushHead, flushTail, flushAll));

    assign waitData = mshrValid[mshrId] && !mshrDataReady[mshrId];

    // A flushed load must not wait on an MSHR that may never fill
    assign blocked = valid && !flushed && (op == opLoad) && hasMshr && waitData;

endmodule

// File: hdl/replayPkg.sv
/*
 * Replay queue shared definitions
 * Op kind carried by each lane and default sizing of the queue
 */

package replayPkg;

    // Kind of op held in a replay lane
    typedef enum logic [1:0] {
        opInt   = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } replayOpType;

    // Lanes per queue entry
    localparam int defaultLaneNum = 2;
    // Queue depth in entries
    localparam int defaultEntryNum = 16;
    // Largest stored gap between two pushes
    localparam int defaultMaxInterval = 7;
    // Entries kept free once the upper stages are told to stall
    localparam int defaultStallMargin = 3;
    // Miss status holding registers in the load unit
    localparam int defaultMshrNum = 4;
    // Active list depth
    localparam int defaultActiveListNum = 32;

endpackage

// File: hdl/replayQueue.sv
/*
 * Scheduler replay queue
 * Records ops to be re-issued and replays them in order with the
 * original spacing, dropping selectively flushed lanes
 */

module replayQueue #(
    parameter int LANE_NUM = replayPkg::defaultLaneNum,
    parameter int ENTRY_NUM = replayPkg::defaultEntryNum,
    parameter int MAX_INTERVAL = replayPkg::defaultMaxInterval,
    parameter int STALL_MARGIN = replayPkg::defaultStallMargin,
    parameter int MSHR_NUM = replayPkg::defaultMshrNum,
    parameter int ACTIVE_LIST_NUM = replayPkg::defaultActiveListNum
) (
    input  logic clk,
    input  logic rstN,
    input  logic [LANE_NUM-1:0] recValid,
    input  replayPkg::replayOpType [LANE_NUM-1:0] recOp,
    input  logic [LANE_NUM-1:0][$clog2(ACTIVE_LIST_NUM)-1:0] recAlPtr,
    input  logic [LANE_NUM-1:0] recHasMshr,
    input  logic [LANE_NUM-1:0][$clog2(MSHR_NUM)-1:0] recMshrId,
    input  logic [LANE_NUM-1:0][7:0] recTag,
    input  logic flushStart,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] flushHead,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] flushTail,
    input  logic flushAll,
    input  logic [MSHR_NUM-1:0] mshrValid,
    input  logic [MSHR_NUM-1:0] mshrDataReady,
    output logic replay,
    output logic [LANE_NUM-1:0] repValid,
    output replayPkg::replayOpType [LANE_NUM-1:0] repOp,
    output logic [LANE_NUM-1:0][$clog2(ACTIVE_LIST_NUM)-1:0] repAlPtr,
    output logic [LANE_NUM-1:0][7:0] repTag,
    output logic stallUpper,
    output logic flushedOpExist
);
    import replayPkg::*;

    localparam int alWidth = $clog2(ACTIVE_LIST_NUM);
    localparam int mshrWidth = $clog2(MSHR_NUM);
    localparam int cntWidth = $clog2(ENTRY_NUM + 1);

    logic headReady;
    logic [LANE_NUM-1:0] headValid;
    replayOpType [LANE_NUM-1:0] headOp;
    logic [LANE_NUM-1:0][alWidth-1:0] headAlPtr;
    logic [LANE_NUM-1:0] headHasMshr;
    logic [LANE_NUM-1:0][mshrWidth-1:0] headMshrId;
    logic [LANE_NUM-1:0][7:0] headTag;
    logic [cntWidth-1:0] count;
    logic recValidRange;
    logic [alWidth-1:0] recHead;
    logic [alWidth-1:0] recTail;
    logic recAll;
    logic [LANE_NUM-1:0] laneFlushed;
    logic [LANE_NUM-1:0] laneBlocked;
    logic pop;

    replayQueueStore #(
        .LANE_NUM(LANE_NUM),
        .ENTRY_NUM(ENTRY_NUM),
        .MAX_INTERVAL(MAX_INTERVAL),
        .MSHR_NUM(MSHR_NUM),
        .ACTIVE_LIST_NUM(ACTIVE_LIST_NUM)
    ) replayQueueStore_i (
        .clk(clk), .rstN(rstN),
        .recValid(recValid), .recOp(recOp), .recAlPtr(recAlPtr),
        .recHasMshr(recHasMshr), .recMshrId(recMshrId), .recTag(recTag),
        .pop(pop), .replay(replay),
        .flushStart(flushStart), .flushHead(flushHead),
        .flushTail(flushTail), .flushAll(flushAll),
        .headReady(headReady), .headValid(headValid), .headOp(headOp),
        .headAlPtr(headAlPtr), .headHasMshr(headHasMshr),
        .headMshrId(headMshrId), .headTag(headTag), .count(count),
        .recValidRange(recValidRange), .recHead(recHead),
        .recTail(recTail), .recAll(recAll)
    );

    // One check per head lane
    for (genvar i = 0; i < LANE_NUM; i++) begin : laneGen
        replayLaneCheck #(
            .MSHR_NUM(MSHR_NUM),
            .ACTIVE_LIST_NUM(ACTIVE_LIST_NUM)
        ) replayLaneCheck_i (
            .alPtr(headAlPtr[i]), .op(headOp[i]), .hasMshr(headHasMshr[i]),
            .mshrId(headMshrId[i]), .valid(headValid[i]),
            .recValidRange(recValidRange), .recHead(recHead),
            .recTail(recTail), .recAll(recAll),
            .flushStart(flushStart), .flushHead(flushHead),
            .flushTail(flushTail), .flushAll(flushAll),
            .mshrValid(mshrValid), .mshrDataReady(mshrDataReady),
            .flushed(laneFlushed[i]), .blocked(laneBlocked[i])
        );
    end

    replayIssueReg #(
        .LANE_NUM(LANE_NUM),
        .ENTRY_NUM(ENTRY_NUM),
        .STALL_MARGIN(STALL_MARGIN),
        .ACTIVE_LIST_NUM(ACTIVE_LIST_NUM)
    ) replayIssueReg_i (
        .clk(clk), .rstN(rstN),
        .headReady(headReady), .headValid(headValid), .headOp(headOp),
        .headAlPtr(headAlPtr), .headTag(headTag),
        .laneFlushed(laneFlushed), .laneBlocked(laneBlocked), .count(count),
        .pop(pop), .replay(replay), .repValid(repValid), .repOp(repOp),
        .repAlPtr(repAlPtr), .repTag(repTag), .stallUpper(stallUpper)
    );

    assign flushedOpExist = recValidRange;

endmodule

// File: hdl/replayQueueStore.sv
/*
 * Replay queue storage
 * Circular entry array with head/tail pointers and entry count,
 * push/pop interval counters and the recorded selective-flush range
 */

module replayQueueStore #(
    parameter int LANE_NUM = 2,
    parameter int ENTRY_NUM = 16,
    parameter int MAX_INTERVAL = 7,
    parameter int MSHR_NUM = 4,
    parameter int ACTIVE_LIST_NUM = 32
) (
    input  logic clk,
    input  logic rstN,
    input  logic [LANE_NUM-1:0] recValid,
    input  replayPkg::replayOpType [LANE_NUM-1:0] recOp,
    input  logic [LANE_NUM-1:0][$clog2(ACTIVE_LIST_NUM)-1:0] recAlPtr,
    input  logic [LANE_NUM-1:0] recHasMshr,
    input  logic [LANE_NUM-1:0][$clog2(MSHR_NUM)-1:0] recMshrId,
    input  logic [LANE_NUM-1:0][7:0] recTag,
    input  logic pop,
    input  logic replay,
    input  logic flushStart,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] flushHead,
    input  logic [$clog2(ACTIVE_LIST_NUM)-1:0] flushTail,
    input  logic flushAll,
    output logic headReady,
    output logic [LANE_NUM-1:0] headValid,
    output replayPkg::replayOpType [LANE_NUM-1:0] headOp,
    output logic [LANE_NUM-1:0][$clog2(ACTIVE_LIST_NUM)-1:0] headAlPtr,
    output logic [LANE_NUM-1:0] headHasMshr,
    output logic [LANE_NUM-1:0][$clog2(MSHR_NUM)-1:0] headMshrId,
    output logic [LANE_NUM-1:0][7:0] headTag,
    output logic [$clog2(ENTRY_NUM+1)-1:0] count,
    output logic recValidRange,
    output logic [$clog2(ACTIVE_LIST_NUM)-1:0] recHead,
    output logic [$clog2(ACTIVE_LIST_NUM)-1:0] recTail,
    output logic recAll
);
    import replayPkg::*;

    localparam int alWidth = $clog2(ACTIVE_LIST_NUM);
    localparam int mshrWidth = $clog2(MSHR_NUM);
    localparam int cntWidth = $clog2(ENTRY_NUM + 1);
    localparam int ptrWidth = (ENTRY_NUM > 1) ? $clog2(ENTRY_NUM) : 1;
    localparam int intWidth = $clog2(MAX_INTERVAL + 1);

    // Entry array, one row per push
    logic [LANE_NUM-1:0] validMem [ENTRY_NUM];
    replayOpType [LANE_NUM-1:0] opMem [ENTRY_NUM];
    logic [LANE_NUM-1:0][alWidth-1:0] alPtrMem [ENTRY_NUM];
    logic [LANE_NUM-1:0] hasMshrMem [ENTRY_NUM];
    logic [LANE_NUM-1:0][mshrWidth-1:0] mshrIdMem [ENTRY_NUM];
    logic [LANE_NUM-1:0][7:0] tagMem [ENTRY_NUM];
    logic [intWidth-1:0] intervalMem [ENTRY_NUM];

    logic [ptrWidth-1:0] headPtr;
    logic [ptrWidth-1:0] tailPtr;
    logic push;
    logic empty;
    logic full;

    logic [intWidth-1:0] sincePush;
    logic [intWidth-1:0] sincePop;
    logic [intWidth-1:0] pushInterval;
    logic pushSeen;
    logic [cntWidth-1:0] recCount;

    function automatic logic [ptrWidth-1:0] advance(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(ENTRY_NUM - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == cntWidth'(ENTRY_NUM));
    assign push = (|recValid) && !full;

    // First push after reset has no predecessor
    assign pushInterval = pushSeen ? sincePush : '0;

    always_ff @(posedge clk) begin
        if (push) begin
            validMem[tailPtr] <= recValid;
            opMem[tailPtr] <= recOp;
            alPtrMem[tailPtr] <= recAlPtr;
            hasMshrMem[tailPtr] <= recHasMshr;
            mshrIdMem[tailPtr] <= recMshrId;
            tagMem[tailPtr] <= recTag;
            intervalMem[tailPtr] <= pushInterval;
        end
    end

    // Combinational read of the head entry
    assign headValid = validMem[headPtr];
    assign headOp = opMem[headPtr];
    assign headAlPtr = alPtrMem[headPtr];
    assign headHasMshr = hasMshrMem[headPtr];
    assign headMshrId = mshrIdMem[headPtr];
    assign headTag = tagMem[headPtr];

    assign headReady = !empty && (sincePop >= intervalMem[headPtr]);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= advance(tailPtr);
            end
            if (pop) begin
                headPtr <= advance(headPtr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Saturating gap counters, restart at one on each event
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sincePush <= '0;
            sincePop <= '0;
            pushSeen <= 1'b0;
        end else begin
            if (push) begin
                sincePush <= intWidth'(1);
                pushSeen <= 1'b1;
            end else if (sincePush < intWidth'(MAX_INTERVAL)) begin
                sincePush <= sincePush + 1'b1;
            end
            if (pop) begin
                sincePop <= intWidth'(1);
            end else if (sincePop < intWidth'(MAX_INTERVAL)) begin
                sincePop <= sincePop + 1'b1;
            end
        end
    end

    // Range of the last recovery, live until every entry present then has replayed
    always_ff @(posedge clk) begin
        if (!rstN) begin
            recCount <= '0;
        end else if (flushStart) begin
            recCount <= count;
        end else if (replay && recCount != '0) begin
            recCount <= recCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flushStart) begin
            recHead <= flushHead;
            recTail <= flushTail;
            recAll <= flushAll;
        end
    end

    assign recValidRange = (recCount != '0);

endmodule

// File: verification/replayQueueTb.sv
/*
 * Replay queue testbench
 * Random and directed traffic checked against a model of the queued
 * entries for order, payload, spacing, flush, MSHR wait and stall
 */

module replayQueueTb;
    import replayPkg::*;

    localparam int LANE_NUM = defaultLaneNum;
    localparam int ENTRY_NUM = defaultEntryNum;
    localparam int MAX_INTERVAL = defaultMaxInterval;
    localparam int STALL_MARGIN = defaultStallMargin;
    localparam int MSHR_NUM = defaultMshrNum;
    localparam int ACTIVE_LIST_NUM = defaultActiveListNum;
    localparam int alWidth = $clog2(ACTIVE_LIST_NUM);
    localparam int mshrWidth = $clog2(MSHR_NUM);

    logic clk;
    logic rstN;
    logic [LANE_NUM-1:0] recValid;
    replayOpType [LANE_NUM-1:0] recOp;
    logic [LANE_NUM-1:0][alWidth-1:0] recAlPtr;
    logic [LANE_NUM-1:0] recHasMshr;
    logic [LANE_NUM-1:0][mshrWidth-1:0] recMshrId;
    logic [LANE_NUM-1:0][7:0] recTag;
    logic flushStart;
    logic [alWidth-1:0] flushHead;
    logic [alWidth-1:0] flushTail;
    logic flushAll;
    logic [MSHR_NUM-1:0] mshrValid;
    logic [MSHR_NUM-1:0] mshrDataReady;
    logic replay;
    logic [LANE_NUM-1:0] repValid;
    replayOpType [LANE_NUM-1:0] repOp;
    logic [LANE_NUM-1:0][alWidth-1:0] repAlPtr;
    logic [LANE_NUM-1:0][7:0] repTag;
    logic stallUpper;
    logic flushedOpExist;

    // Model of the queued entries, index 0 is the head
    logic [LANE_NUM-1:0] qValid[$];
    replayOpType [LANE_NUM-1:0] qOp[$];
    logic [LANE_NUM-1:0][alWidth-1:0] qAl[$];
    logic [LANE_NUM-1:0] qHasMshr[$];
    logic [LANE_NUM-1:0][mshrWidth-1:0] qMshr[$];
    logic [LANE_NUM-1:0][7:0] qTag[$];
    int qGap[$];

    int cycleNum;
    int lastPushCycle;
    int lastReplayCycle;
    int replaysSeen;
    int recCount;
    logic pushSeen;
    logic prevReplay;
    logic [alWidth-1:0] recHead;
    logic [alWidth-1:0] recTail;
    logic recAll;
    logic [31:0] rngState;
    string testName;

    replayQueue replayQueue_i (
        .clk(clk), .rstN(rstN),
        .recValid(recValid), .recOp(recOp), .recAlPtr(recAlPtr),
        .recHasMshr(recHasMshr), .recMshrId(recMshrId), .recTag(recTag),
        .flushStart(flushStart), .flushHead(flushHead),
        .flushTail(flushTail), .flushAll(flushAll),
        .mshrValid(mshrValid), .mshrDataReady(mshrDataReady),
        .replay(replay), .repValid(repValid), .repOp(repOp),
        .repAlPtr(repAlPtr), .repTag(repTag),
        .stallUpper(stallUpper), .flushedOpExist(flushedOpExist)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift(rngState);
        return int'(rngState % 32'(n));
    endfunction

    // Offset from head is below the span of the range, modulo the ring
    function automatic logic inFlushRange(input logic [alWidth-1:0] ptr,
            input logic [alWidth-1:0] head, input logic [alWidth-1:0] tail, input logic all);
        logic [alWidth-1:0] offset;
        logic [alWidth-1:0] span;
        offset = ptr - head;
        span = tail - head;
        return all || (offset < span);
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string field, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected) else begin
            failRun($sformatf("Error %s %s: expected 0x%0h, actual 0x%0h",
                testName, field, expected, actual));
        end
    endtask

    // Compares the outputs of the last edge with the model, then updates it
    task automatic observe();
        logic [LANE_NUM-1:0] flushedMask;
        logic [LANE_NUM-1:0] expValid;
        logic headBlocked;
        int sizeBefore;
        int gap;
        sizeBefore = qValid.size();
        cycleNum++;
        if (replayQueue_i.replayQueueAssert_i.failures != 0) begin
            failRun("A concurrent assertion on the DUT ports failed");
        end
        flushedMask = '0;
        headBlocked = 1'b0;
        for (int i = 0; i < LANE_NUM; i++) begin
            if (sizeBefore > 0) begin
                flushedMask[i] =
                    (recCount != 0 && inFlushRange(qAl[0][i], recHead, recTail, recAll))
                    || (flushStart && inFlushRange(qAl[0][i], flushHead, flushTail, flushAll));
                if (qValid[0][i] && !flushedMask[i] && qOp[0][i] == opLoad && qHasMshr[0][i]
                        && mshrValid[qMshr[0][i]] && !mshrDataReady[qMshr[0][i]]) begin
                    headBlocked = 1'b1;
                end
            end
        end
        if (replay) begin
            assert (sizeBefore > 0) else failRun("Replay seen while the model queue is empty");
            assert (!headBlocked) else failRun("Head replayed while its load waits on MSHR data");
            expValid = qValid[0] & ~flushedMask;
            checkValue("repValid", 32'(expValid), 32'(repValid));
            for (int i = 0; i < LANE_NUM; i++) begin
                if (expValid[i]) begin
                    checkValue("repOp", 32'(qOp[0][i]), 32'(repOp[i]));
                    checkValue("repAlPtr", 32'(qAl[0][i]), 32'(repAlPtr[i]));
                    checkValue("repTag", 32'(qTag[0][i]), 32'(repTag[i]));
                end
            end
            if (replaysSeen > 0) begin
                assert (cycleNum - lastReplayCycle >= qGap[0]) else begin
                    failRun($sformatf("Error %s spacing: expected gap of at least %0d, actual %0d",
                        testName, qGap[0], cycleNum - lastReplayCycle));
                end
            end
            lastReplayCycle = cycleNum;
            replaysSeen++;
            qValid.delete(0);
            qOp.delete(0);
            qAl.delete(0);
            qHasMshr.delete(0);
            qMshr.delete(0);
            qTag.delete(0);
            qGap.delete(0);
        end else begin
            checkValue("idle repValid", 32'(0), 32'(repValid));
        end
        if ((|recValid) && sizeBefore < ENTRY_NUM) begin
            gap = pushSeen ? cycleNum - lastPushCycle : 0;
            if (gap > MAX_INTERVAL) begin
                gap = MAX_INTERVAL;
            end
            qValid.push_back(recValid);
            qOp.push_back(recOp);
            qAl.push_back(recAlPtr);
            qHasMshr.push_back(recHasMshr);
            qMshr.push_back(recMshrId);
            qTag.push_back(recTag);
            qGap.push_back(gap);
            pushSeen = 1'b1;
            lastPushCycle = cycleNum;
        end
        // Recorded range lives for as many replays as entries present at recovery
        if (flushStart) begin
            recCount = sizeBefore;
            recHead = flushHead;
            recTail = flushTail;
            recAll = flushAll;
        end else if (prevReplay && recCount > 0) begin
            recCount--;
        end
        prevReplay = replay;
        checkValue("flushedOpExist", 32'(recCount != 0), 32'(flushedOpExist));
        checkValue("stallUpper", 32'(replay || qValid.size() >= ENTRY_NUM - STALL_MARGIN),
            32'(stallUpper));
    endtask

    task automatic tick();
        @(negedge clk);
        observe();
    endtask

    task automatic clearInputs();
        recValid = '0;
        recOp = '{default: opInt};
        recAlPtr = '0;
        recHasMshr = '0;
        recMshrId = '0;
        recTag = '0;
        flushStart = 1'b0;
        flushHead = '0;
        flushTail = '0;
        flushAll = 1'b0;
    endtask

    task automatic loadRandomEntry();
        recValid = LANE_NUM'(randBelow(1 << LANE_NUM));
        if (recValid == '0) begin
            recValid[0] = 1'b1;
        end
        for (int i = 0; i < LANE_NUM; i++) begin
            recOp[i] = replayOpType'(2'(randBelow(3)));
            recAlPtr[i] = alWidth'(randBelow(ACTIVE_LIST_NUM));
            recHasMshr[i] = 1'(randBelow(2));
            recMshrId[i] = mshrWidth'(randBelow(MSHR_NUM));
            recTag[i] = 8'(randBelow(256));
        end
    endtask

    // Sparse pushes give push gaps both below and above the cap
    task automatic randomCycle(input int flushOdds);
        clearInputs();
        if (randBelow(3) == 0 && !stallUpper) begin
            loadRandomEntry();
        end
        if (flushOdds > 0 && randBelow(flushOdds) == 0) begin
            flushStart = 1'b1;
            flushHead = alWidth'(randBelow(ACTIVE_LIST_NUM));
            flushTail = alWidth'(randBelow(ACTIVE_LIST_NUM));
            flushAll = (randBelow(8) == 0);
        end
        tick();
    endtask

    task automatic waitDrain(input int limit);
        int waited;
        waited = 0;
        clearInputs();
        while (qValid.size() != 0 || replay) begin
            if (waited >= limit) begin
                failRun("Timeout while waiting for the queue to drain");
            end
            tick();
            waited++;
        end
    endtask

    task automatic waitReplay(input int limit);
        int waited;
        waited = 0;
        clearInputs();
        while (!replay) begin
            if (waited >= limit) begin
                failRun("Timeout while waiting for the released load to replay");
            end
            tick();
            waited++;
        end
    endtask

    initial begin
        rngState = 32'd99;
        testName = "reset";
        cycleNum = 0;
        lastPushCycle = 0;
        lastReplayCycle = 0;
        replaysSeen = 0;
        recCount = 0;
        pushSeen = 1'b0;
        prevReplay = 1'b0;
        rstN = 1'b0;
        mshrValid = '0;
        mshrDataReady = '0;
        clearInputs();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkValue("replay", 32'(0), 32'(replay));
        checkValue("repValid", 32'(0), 32'(repValid));
        checkValue("stallUpper", 32'(0), 32'(stallUpper));
        checkValue("flushedOpExist", 32'(0), 32'(flushedOpExist));

        testName = "order";
        for (int n = 0; n < 80; n++) begin
            randomCycle(0);
        end
        waitDrain(600);

        testName = "flush";
        for (int n = 0; n < 120; n++) begin
            randomCycle(12);
        end
        waitDrain(600);

        // Load on a pending MSHR holds the head while the queue fills behind it
        testName = "mshr wait";
        mshrValid = MSHR_NUM'(2);
        clearInputs();
        recValid[0] = 1'b1;
        recOp[0] = opLoad;
        recHasMshr[0] = 1'b1;
        recMshrId[0] = mshrWidth'(1);
        recTag[0] = 8'hA5;
        tick();
        // Uneven push gaps, so the backlog replays at its stored spacing
        for (int n = 0; n < 60; n++) begin
            clearInputs();
            if (!stallUpper && randBelow(2) == 0) begin
                loadRandomEntry();
            end
            tick();
        end
        assert (qValid.size() >= ENTRY_NUM - STALL_MARGIN) else begin
            failRun("Queue did not fill behind the waiting load");
        end
        mshrDataReady[1] = 1'b1;
        waitReplay(20);

        // Recovery while the backlog waits, so queued lanes meet the recorded range
        testName = "backlog flush";
        clearInputs();
        flushStart = 1'b1;
        flushHead = alWidth'(randBelow(ACTIVE_LIST_NUM));
        flushTail = alWidth'(randBelow(ACTIVE_LIST_NUM));
        tick();
        waitDrain(600);

        clearInputs();
        repeat (4) tick();
        if (replayQueue_i.replayQueueAssert_i.failures == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            failRun("Concurrent assertions on the DUT ports failed");
        end
    end

endmodule

// File: verification/replayQueue_assert.sv
/*
 * Replay queue port assertions
 * Reset state, replay strobe and flush status rules on the top level
 */

module replayQueueAssert #(
    parameter int LANE_NUM = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic replay,
    input  logic [LANE_NUM-1:0] repValid,
    input  logic stallUpper,
    input  logic flushedOpExist,
    input  logic flushStart
);

    // Number of failed assertions
    int failures = 0;

    // Outputs come out of reset quiet
    resetQuiet: assert property (@(posedge clk)
        !rstN |=> !replay && (repValid == '0) && !stallUpper && !flushedOpExist)
        else begin
            failures++;
            $error("Outputs not idle after a reset cycle");
        end

    // Surviving lanes only appear with the replay strobe
    validNeedsReplay: assert property (@(posedge clk) disable iff (!rstN)
        (|repValid) |-> replay)
        else begin
            failures++;
            $error("repValid set without replay");
        end

    replayStalls: assert property (@(posedge clk) disable iff (!rstN)
        replay |-> stallUpper)
        else begin
            failures++;
            $error("stallUpper low during a replay");
        end

    // Flush status only rises after a recovery
    flushedNeedsRecovery: assert property (@(posedge clk) disable iff (!rstN)
        !flushedOpExist && !flushStart |=> !flushedOpExist)
        else begin
            failures++;
            $error("flushedOpExist rose without flushStart");
        end

    flushedFallsOnReplay: assert property (@(posedge clk) disable iff (!rstN)
        $fell(flushedOpExist) |-> $past(replay || flushStart))
        else begin
            failures++;
            $error("flushedOpExist fell without a replay");
        end

endmodule

bind replayQueue replayQueueAssert #(
    .LANE_NUM(LANE_NUM)
) replayQueueAssert_i (
    .clk(clk),
    .rstN(rstN),
    .replay(replay),
    .repValid(repValid),
    .stallUpper(stallUpper),
    .flushedOpExist(flushedOpExist),
    .flushStart(flushStart)
);
